/* Bender.yml */
package:
  name: kcpu

sources:
  - target: rtl
    include_dirs:
      - common
    files:
      - common/kcpu_pkg.sv
      - common/kcpu_if.sv
      - rtl/kcpu_ctrl.sv
      - rtl/kcpu_memctrl.sv
      - rtl/kcpu_alu.sv
      - rtl/kcpu_regs.sv
      - rtl/kcpu.sv
  - target: tb
    include_dirs:
      - common
    files:
      - tb/kcpu_chk.sv
      - tb/kcpu_tb.sv

/* build.f */
+incdir+common
common/kcpu_pkg.sv
common/kcpu_if.sv
rtl/kcpu_ctrl.sv
rtl/kcpu_memctrl.sv
rtl/kcpu_alu.sv
rtl/kcpu_regs.sv
rtl/kcpu.sv
tb/kcpu_chk.sv
tb/kcpu_tb.sv

/* common/kcpu_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one request per access, done closes it
interface kcpu_mem_if;
    logic        req;
    logic        we;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        done;

    modport ctrl (output req, we, addr, wdata, input rdata, done);
    modport memctrl (input req, we, addr, wdata, output rdata, done);
endinterface

// sequencer strobes towards the datapath
interface kcpu_exec_if;
    import kcpu_pkg::*;

    kcpu_alu_e   alu_op;
    kcpu_mode_e  mode;
    logic [15:0] imm;
    logic        ld_a;
    logic        ld_b;
    logic        ld_x;
    logic        ld_cc;
    logic        ld_d;
    logic        pc_load;
    logic        pc_inc;
    logic [15:0] pc_val;
    logic [1:0]  st_sel;    // 0 A, 1 B, 2 CC
    logic        mul_start;
    logic        alu_busy;
    logic [3:0]  cc;

    modport ctrl (
        output alu_op, mode, imm, ld_a, ld_b, ld_x, ld_cc, ld_d,
               pc_load, pc_inc, pc_val, st_sel, mul_start,
        input  alu_busy, cc
    );
    modport alu (input alu_op, mul_start, output alu_busy);
    modport regs (
        input  mode, imm, ld_a, ld_b, ld_x, ld_cc, ld_d,
               pc_load, pc_inc, pc_val, st_sel,
        output cc
    );
endinterface

`default_nettype wire

/* common/kcpu_params.svh */
`ifndef KCPU_PARAMS_SVH
`define KCPU_PARAMS_SVH

// high byte of the reset vector, low byte follows at +1
`define KCPU_RESET_VEC 16'hFFFE

// shift-add iterations for MUL
`define KCPU_MUL_STEPS 8

// field widths of the encoded types
`define KCPU_OP_W    8
`define KCPU_STATE_W 4
`define KCPU_ALU_W   3

`endif

/* common/kcpu_pkg.sv */
`default_nettype none
`include "kcpu_params.svh"

package kcpu_pkg;

    // 6809-like codes, bit 5 set marks the indexed form
    typedef enum logic [`KCPU_OP_W-1:0] {
        OP_NOP      = 8'h12,
        OP_BRA      = 8'h20,
        OP_BNE      = 8'h26,
        OP_BEQ      = 8'h27,
        OP_MUL      = 8'h3D,
        OP_SUBA_IMM = 8'h80,
        OP_ANDA_IMM = 8'h84,
        OP_LDA_IMM  = 8'h86,
        OP_EORA_IMM = 8'h88,
        OP_ORA_IMM  = 8'h8A,
        OP_ADDA_IMM = 8'h8B,
        OP_LDX_IMM  = 8'h8E,
        OP_SUBA_IDX = 8'hA0,
        OP_ANDA_IDX = 8'hA4,
        OP_LDA_IDX  = 8'hA6,
        OP_STA_IDX  = 8'hA7,
        OP_EORA_IDX = 8'hA8,
        OP_ORA_IDX  = 8'hAA,
        OP_ADDA_IDX = 8'hAB,
        OP_LDX_IDX  = 8'hAE,
        OP_STC_IDX  = 8'hAF,
        OP_LDB_IMM  = 8'hC6,
        OP_LDB_IDX  = 8'hE6,
        OP_STB_IDX  = 8'hE7
    } kcpu_op_e;

    typedef enum logic [`KCPU_STATE_W-1:0] {
        RESET_HI, RESET_LO, FETCH, OPERAND, OPERAND_LO,
        EXEC, MEM_RD, MEM_WR, MUL_WAIT
    } kcpu_state_e;

    typedef enum logic [`KCPU_ALU_W-1:0] {
        ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_EOR, ALU_MUL
    } kcpu_alu_e;

    typedef enum logic {
        MODE_IMM,
        MODE_IDX
    } kcpu_mode_e;

    // condition code bit positions
    localparam int CC_N = 3;
    localparam int CC_Z = 2;
    localparam int CC_V = 1;
    localparam int CC_C = 0;

endpackage

`default_nettype wire

/* rtl/kcpu.sv */
`timescale 1ns/1ps
`default_nettype none

module kcpu (
    input  logic        clk,
    input  logic        rst,
    input  logic        halt,
    input  logic        dtack,
    input  logic [7:0]  din,
    output logic [7:0]  dout,
    output logic [15:0] addr,
    output logic        we,
    output logic        bus_req
);

    logic [15:0] pc;
    logic [15:0] x;
    logic [15:0] rslt;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  opnd;
    logic [7:0]  st_data;
    logic [3:0]  cc_alu;

    kcpu_mem_if  mem_if ();
    kcpu_exec_if exec_if ();

    kcpu_ctrl u_ctrl (
        .clk      ( clk           ),
        .rst      ( rst           ),
        .halt     ( halt          ),
        .mem      ( mem_if.ctrl   ),
        .ex       ( exec_if.ctrl  ),
        .pc       ( pc            ),
        .x        ( x             ),
        .st_data  ( st_data       )
    );

    // memory bus
    kcpu_memctrl u_memctrl (
        .clk      ( clk            ),
        .rst      ( rst            ),
        .mem      ( mem_if.memctrl ),
        .dtack    ( dtack          ),
        .din      ( din            ),
        .dout     ( dout           ),
        .addr     ( addr           ),
        .we       ( we             ),
        .bus_req  ( bus_req        )
    );

    kcpu_alu u_alu (
        .clk      ( clk           ),
        .rst      ( rst           ),
        .ex       ( exec_if.alu   ),
        .a        ( a             ),
        .b        ( b             ),
        .opnd     ( opnd          ),
        .cc_in    ( exec_if.cc    ),
        .rslt     ( rslt          ),
        .cc_out   ( cc_alu        )
    );

    kcpu_regs u_regs (
        .clk      ( clk           ),
        .rst      ( rst           ),
        .ex       ( exec_if.regs  ),
        .mdata    ( mem_if.rdata  ),
        .rslt     ( rslt          ),
        .cc_alu   ( cc_alu        ),
        .a        ( a             ),
        .b        ( b             ),
        .x        ( x             ),
        .pc       ( pc            ),
        .opnd     ( opnd          ),
        .st_data  ( st_data       )
    );

endmodule

`default_nettype wire

/* rtl/kcpu_alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "kcpu_params.svh"

module kcpu_alu (
    input  logic        clk,
    input  logic        rst,
    kcpu_exec_if.alu    ex,
    input  logic [7:0]  a,
    input  logic [7:0]  b,
    input  logic [7:0]  opnd,
    input  logic [3:0]  cc_in,
    output logic [15:0] rslt,
    output logic [3:0]  cc_out
);
    import kcpu_pkg::*;

    localparam logic [3:0] STEP_LAST = 4'(`KCPU_MUL_STEPS - 1);

    logic [7:0]  r8;
    logic        c;
    logic        v;
    logic [15:0] prod;
    logic [7:0]  mcand;
    logic [8:0]  step;
    logic [3:0]  cnt;
    logic        busy;

    always_comb begin
        r8 = opnd;
        c  = cc_in[CC_C];
        v  = 1'b0;
        case (ex.alu_op)
            ALU_ADD: begin
                {c, r8} = {1'b0, a} + {1'b0, opnd};
                v = (a[7] == opnd[7]) && (r8[7] != a[7]);
            end
            ALU_SUB: begin
                // c comes out as the borrow
                {c, r8} = {1'b0, a} - {1'b0, opnd};
                v = (a[7] != opnd[7]) && (r8[7] != a[7]);
            end
            ALU_AND: r8 = a & opnd;
            ALU_OR:  r8 = a | opnd;
            ALU_EOR: r8 = a ^ opnd;
            default: r8 = opnd;
        endcase
    end

    always_comb begin
        if (ex.alu_op == ALU_MUL) begin
            rslt         = prod;
            cc_out[CC_N] = cc_in[CC_N];
            cc_out[CC_Z] = (prod == 16'h0000);
            cc_out[CC_V] = cc_in[CC_V];
            cc_out[CC_C] = prod[7];
        end else begin
            rslt         = {8'h00, r8};
            cc_out[CC_N] = r8[7];
            cc_out[CC_Z] = (r8 == 8'h00);
            cc_out[CC_V] = v;
            cc_out[CC_C] = c;
        end
    end

    // shift-add, multiplier in the low half shifts out as the product comes in
    assign step        = {1'b0, prod[15:8]} + (prod[0] ? {1'b0, mcand} : 9'd0);
    assign ex.alu_busy = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (ex.mul_start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 4'd1;
            if (cnt == STEP_LAST) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex.mul_start) begin
            prod  <= {8'h00, b};
            mcand <= a;
        end else if (busy) begin
            prod <= {step, prod[7:1]};
        end
    end

endmodule

`default_nettype wire

/* rtl/kcpu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "kcpu_params.svh"

module kcpu_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  logic        halt,
    kcpu_mem_if.ctrl    mem,
    kcpu_exec_if.ctrl   ex,
    input  logic [15:0] pc,
    input  logic [15:0] x,
    input  logic [7:0]  st_data
);
    import kcpu_pkg::*;

    kcpu_state_e state;
    kcpu_op_e    op;
    kcpu_op_e    dec_op;
    logic [7:0]  opr_hi;
    logic [7:0]  opr_lo;
    logic        pend;
    logic        second;
    logic        mem_state;
    logic        wr_a, wr_b, wr_x, is_st, is_mul, is_br, is_idx, has_opnd, taken;
    logic [15:0] idx_addr;
    logic [15:0] br_target;

    // opcode byte is decoded straight off the bus while fetching
    assign dec_op = (state == FETCH) ? kcpu_op_e'(mem.rdata) : op;

    assign wr_a = dec_op inside {OP_LDA_IMM, OP_LDA_IDX, OP_ADDA_IMM, OP_ADDA_IDX,
                                 OP_SUBA_IMM, OP_SUBA_IDX, OP_ANDA_IMM, OP_ANDA_IDX,
                                 OP_ORA_IMM, OP_ORA_IDX, OP_EORA_IMM, OP_EORA_IDX};
    assign wr_b     = dec_op inside {OP_LDB_IMM, OP_LDB_IDX};
    assign wr_x     = dec_op inside {OP_LDX_IMM, OP_LDX_IDX};
    assign is_st    = dec_op inside {OP_STA_IDX, OP_STB_IDX, OP_STC_IDX};
    assign is_br    = dec_op inside {OP_BRA, OP_BEQ, OP_BNE};
    assign is_mul   = (dec_op == OP_MUL);
    assign is_idx   = dec_op[5] && (wr_a || wr_b || wr_x || is_st);
    assign has_opnd = wr_a || wr_b || wr_x || is_st || is_br;

    assign taken = (dec_op == OP_BRA) ||
                   (dec_op == OP_BEQ && ex.cc[CC_Z]) ||
                   (dec_op == OP_BNE && !ex.cc[CC_Z]);

    // index adder, second byte of LDX sits one above
    assign idx_addr  = x + {{8{opr_lo[7]}}, opr_lo} + {15'd0, second};
    assign br_target = pc + {{8{opr_lo[7]}}, opr_lo};

    always_comb begin
        case (dec_op)
            OP_ADDA_IMM, OP_ADDA_IDX: ex.alu_op = ALU_ADD;
            OP_SUBA_IMM, OP_SUBA_IDX: ex.alu_op = ALU_SUB;
            OP_ANDA_IMM, OP_ANDA_IDX: ex.alu_op = ALU_AND;
            OP_ORA_IMM, OP_ORA_IDX:   ex.alu_op = ALU_OR;
            OP_EORA_IMM, OP_EORA_IDX: ex.alu_op = ALU_EOR;
            OP_MUL:                   ex.alu_op = ALU_MUL;
            default:                  ex.alu_op = ALU_PASS;
        endcase
    end

    assign ex.mode   = is_idx ? MODE_IDX : MODE_IMM;
    assign ex.imm    = {opr_hi, opr_lo};
    assign ex.st_sel = (dec_op == OP_STB_IDX) ? 2'd1 : (dec_op == OP_STC_IDX) ? 2'd2 : 2'd0;

    assign ex.ld_a      = (state == EXEC) && wr_a;
    assign ex.ld_b      = (state == EXEC) && wr_b;
    assign ex.ld_x      = (state == EXEC) && wr_x;
    assign ex.ld_d      = (state == MUL_WAIT) && !ex.alu_busy;
    assign ex.ld_cc     = ((state == EXEC) && (wr_a || wr_b)) || ex.ld_d;
    assign ex.mul_start = (state == EXEC) && is_mul;
    assign ex.pc_inc    = mem.done && (state inside {FETCH, OPERAND, OPERAND_LO});
    assign ex.pc_load   = ((state == RESET_LO) && mem.done) || ((state == EXEC) && taken);
    assign ex.pc_val    = (state == RESET_LO) ? {opr_hi, mem.rdata} : br_target;

    // bus request, halt only holds off a new opcode fetch
    assign mem_state = state inside {RESET_HI, RESET_LO, FETCH, OPERAND,
                                     OPERAND_LO, MEM_RD, MEM_WR};
    assign mem.req   = mem_state && !pend && !((state == FETCH) && halt);
    assign mem.we    = (state == MEM_WR);
    assign mem.wdata = st_data;

    always_comb begin
        case (state)
            RESET_HI:       mem.addr = `KCPU_RESET_VEC;
            RESET_LO:       mem.addr = `KCPU_RESET_VEC | 16'h0001;
            MEM_RD, MEM_WR: mem.addr = idx_addr;
            default:        mem.addr = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= RESET_HI;
            op     <= OP_NOP;
            pend   <= 1'b0;
            second <= 1'b0;
        end else begin
            if (mem.req) begin
                pend <= 1'b1;
            end
            if (mem.done) begin
                pend <= 1'b0;
            end
            case (state)
                RESET_HI: if (mem.done) state <= RESET_LO;
                RESET_LO: if (mem.done) state <= FETCH;
                FETCH: begin
                    if (mem.done) begin
                        op    <= dec_op;
                        state <= has_opnd ? OPERAND : EXEC;
                    end
                end
                OPERAND: begin
                    if (mem.done) begin
                        if (wr_x && !is_idx) begin
                            state <= OPERAND_LO;
                        end else if (is_st) begin
                            state <= MEM_WR;
                        end else begin
                            state <= is_idx ? MEM_RD : EXEC;
                        end
                    end
                end
                OPERAND_LO: if (mem.done) state <= EXEC;
                MEM_RD: begin
                    if (mem.done) begin
                        // LDX needs a second byte
                        second <= wr_x && !second;
                        if (!wr_x || second) begin
                            state <= EXEC;
                        end
                    end
                end
                MEM_WR:   if (mem.done) state <= FETCH;
                EXEC:     state <= is_mul ? MUL_WAIT : FETCH;
                MUL_WAIT: if (!ex.alu_busy) state <= FETCH;
                default:  state <= FETCH;
            endcase
        end
    end

    // operand bytes
    always_ff @(posedge clk) begin
        if (mem.done) begin
            case (state)
                RESET_HI: opr_hi <= mem.rdata;
                OPERAND:  opr_lo <= mem.rdata;
                OPERAND_LO: begin
                    opr_hi <= opr_lo;
                    opr_lo <= mem.rdata;
                end
                MEM_RD: if (!second) opr_hi <= mem.rdata;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/kcpu_memctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module kcpu_memctrl (
    input  logic        clk,
    input  logic        rst,
    kcpu_mem_if.memctrl mem,
    input  logic        dtack,
    input  logic [7:0]  din,
    output logic [7:0]  dout,
    output logic [15:0] addr,
    output logic        we,
    output logic        bus_req
);

    typedef enum logic {
        M_IDLE,
        M_BUS
    } bus_state_e;

    bus_state_e state;
    logic [7:0] rdata;
    logic       done;

    assign mem.rdata = rdata;
    assign mem.done  = done;

    // control side
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= M_IDLE;
            bus_req <= 1'b0;
            we      <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (mem.req) begin
                        state   <= M_BUS;
                        bus_req <= 1'b1;
                        we      <= mem.we;
                    end
                end
                M_BUS: begin
                    // stretch until the memory answers
                    if (dtack) begin
                        state   <= M_IDLE;
                        bus_req <= 1'b0;
                        we      <= 1'b0;
                        done    <= 1'b1;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // address and data held for the whole access
    always_ff @(posedge clk) begin
        if (state == M_IDLE && mem.req) begin
            addr <= mem.addr;
            dout <= mem.wdata;
        end
        if (state == M_BUS && dtack) begin
            rdata <= din;
        end
    end

endmodule

`default_nettype wire

/* rtl/kcpu_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module kcpu_regs (
    input  logic        clk,
    input  logic        rst,
    kcpu_exec_if.regs   ex,
    input  logic [7:0]  mdata,
    input  logic [15:0] rslt,
    input  logic [3:0]  cc_alu,
    output logic [7:0]  a,
    output logic [7:0]  b,
    output logic [15:0] x,
    output logic [15:0] pc,
    output logic [7:0]  opnd,
    output logic [7:0]  st_data
);
    import kcpu_pkg::*;

    logic [3:0]  cc;
    logic [15:0] x_val;

    assign ex.cc = cc;

    // immediate byte or the byte just read at X+offset
    assign opnd  = (ex.mode == MODE_IMM) ? ex.imm[7:0] : mdata;
    // indexed LDX gets its high byte from the first read
    assign x_val = (ex.mode == MODE_IMM) ? ex.imm : {ex.imm[15:8], mdata};

    always_comb begin
        case (ex.st_sel)
            2'd0:    st_data = a;
            2'd1:    st_data = b;
            default: st_data = {4'h0, cc};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a  <= 8'h00;
            b  <= 8'h00;
            x  <= 16'h0000;
            pc <= 16'h0000;
            cc <= 4'h0;
        end else begin
            if (ex.ld_d) begin
                // D is A:B with A on top
                a <= rslt[15:8];
                b <= rslt[7:0];
            end else begin
                if (ex.ld_a) begin
                    a <= rslt[7:0];
                end
                if (ex.ld_b) begin
                    b <= rslt[7:0];
                end
            end
            if (ex.ld_x) begin
                x <= x_val;
            end
            if (ex.ld_cc) begin
                cc <= cc_alu;
            end
            if (ex.pc_load) begin
                pc <= ex.pc_val;
            end else if (ex.pc_inc) begin
                pc <= pc + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/kcpu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module kcpu_chk (
    input  logic        clk,
    input  logic        rst,
    input  logic        bus_req,
    input  logic        we,
    input  logic        dtack,
    input  logic [15:0] addr,
    input  logic [7:0]  dout
);

    // read by the testbench at the end of the run
    int fail_cnt = 0;

    // address, direction and write data held until the memory answers
    property bus_held;
        @(posedge clk) disable iff (rst)
            (bus_req && !dtack) |=> (bus_req && $stable(addr) && $stable(we) && $stable(dout));
    endproperty

    property we_in_cycle;
        @(posedge clk) disable iff (rst) we |-> bus_req;
    endproperty

    // one access per dtack
    property ends_on_dtack;
        @(posedge clk) disable iff (rst) (bus_req && dtack) |=> !bus_req;
    endproperty

    property idle_in_reset;
        @(posedge clk) rst |=> (!bus_req && !we);
    endproperty

    assert property (bus_held) else begin
        fail_cnt++;
        $error("bus outputs changed while waiting for dtack");
    end

    assert property (we_in_cycle) else begin
        fail_cnt++;
        $error("we high outside a bus cycle");
    end

    assert property (ends_on_dtack) else begin
        fail_cnt++;
        $error("bus_req still high after dtack");
    end

    assert property (idle_in_reset) else begin
        fail_cnt++;
        $error("bus active during reset");
    end

endmodule

`default_nettype wire

/* tb/kcpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module kcpu_tb;
    import kcpu_pkg::*;

    localparam int NUM_VEC    = 22;
    localparam int RST_CYCLES = 16;
    localparam int MAX_CYCLES = NUM_VEC * 400;

    typedef struct packed {
        logic [7:0] op;
        logic       mode;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] opnd;
        logic [7:0] off;
        logic [7:0] exp_a;
        logic [7:0] exp_b;
        logic [3:0] exp_cc;
    } vec_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        halt;
    logic        dtack = 1'b0;
    logic [7:0]  din = 8'h00;
    logic [7:0]  dout;
    logic [15:0] addr;
    logic        we;
    logic        bus_req;

    logic [7:0]  mem [0:65535];
    vec_t        tbl [0:NUM_VEC-1];
    logic [23:0] wr_q [$];
    logic [15:0] rd_q [$];
    logic [31:0] rnd_state = 32'h83d9_db72;
    logic        active = 1'b0;
    logic [1:0]  wait_cnt = 2'd0;
    logic        spin_hit = 1'b0;
    logic [15:0] spin_addr = 16'h0000;
    logic [15:0] wp;
    int          errors = 0;
    int          checks = 0;

    kcpu DUT (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .halt    ( halt    ),
        .dtack   ( dtack   ),
        .din     ( din     ),
        .dout    ( dout    ),
        .addr    ( addr    ),
        .we      ( we      ),
        .bus_req ( bus_req )
    );

    bind kcpu kcpu_chk u_chk (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .bus_req ( bus_req ),
        .we      ( we      ),
        .dtack   ( dtack   ),
        .addr    ( addr    ),
        .dout    ( dout    )
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_branch(input logic [7:0] op);
        return (op == OP_BRA) || (op == OP_BEQ) || (op == OP_BNE);
    endfunction

    // memory model, answers after 0 to 3 wait cycles
    always @(posedge clk) begin
        if (rst) begin
            dtack    <= 1'b0;
            active   <= 1'b0;
            spin_hit <= 1'b0;
            wr_q.delete();
            rd_q.delete();
        end else if (bus_req && dtack) begin
            dtack  <= 1'b0;
            active <= 1'b0;
            if (we) begin
                mem[addr] <= dout;
                wr_q.push_back({addr, dout});
            end else begin
                rd_q.push_back(addr);
                if (addr == spin_addr) begin
                    spin_hit <= 1'b1;
                end
            end
        end else if (bus_req && !active) begin
            rnd_state = next_rand(rnd_state);
            active <= 1'b1;
            if (rnd_state[31:30] == 2'd0) begin
                dtack <= 1'b1;
                din   <= mem[addr];
            end else begin
                wait_cnt <= rnd_state[31:30] - 2'd1;
            end
        end else if (bus_req) begin
            if (wait_cnt == 2'd0) begin
                dtack <= 1'b1;
                din   <= mem[addr];
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    task automatic load_table();
        // op, mode, a, b, operand, offset, expected a, b, cc
        tbl[0]  = {OP_ADDA_IMM, MODE_IMM, 8'h12, 8'h01, 8'h34, 8'h10, 8'h46, 8'h01, 4'h0};
        tbl[1]  = {OP_ADDA_IMM, MODE_IMM, 8'hFF, 8'h01, 8'h01, 8'hF0, 8'h00, 8'h01, 4'h5};
        tbl[2]  = {OP_ADDA_IDX, MODE_IDX, 8'h7F, 8'h02, 8'h01, 8'h20, 8'h80, 8'h02, 4'hA};
        tbl[3]  = {OP_SUBA_IMM, MODE_IMM, 8'h10, 8'h03, 8'h20, 8'h04, 8'hF0, 8'h03, 4'h9};
        tbl[4]  = {OP_SUBA_IDX, MODE_IDX, 8'h80, 8'h04, 8'h01, 8'hE0, 8'h7F, 8'h04, 4'h2};
        tbl[5]  = {OP_SUBA_IMM, MODE_IMM, 8'h55, 8'h05, 8'h55, 8'h18, 8'h00, 8'h05, 4'h4};
        tbl[6]  = {OP_ANDA_IMM, MODE_IMM, 8'hF0, 8'h80, 8'h3C, 8'h00, 8'h30, 8'h80, 4'h0};
        tbl[7]  = {OP_ANDA_IDX, MODE_IDX, 8'h0F, 8'h00, 8'hF0, 8'h08, 8'h00, 8'h00, 4'h4};
        tbl[8]  = {OP_ORA_IMM,  MODE_IMM, 8'h80, 8'h06, 8'h01, 8'h60, 8'h81, 8'h06, 4'h8};
        tbl[9]  = {OP_ORA_IDX,  MODE_IDX, 8'h00, 8'h07, 8'h00, 8'hFC, 8'h00, 8'h07, 4'h4};
        tbl[10] = {OP_EORA_IMM, MODE_IMM, 8'hFF, 8'h08, 8'h0F, 8'h70, 8'hF0, 8'h08, 4'h8};
        tbl[11] = {OP_EORA_IDX, MODE_IDX, 8'h5A, 8'h09, 8'h5A, 8'h40, 8'h00, 8'h09, 4'h4};
        tbl[12] = {OP_LDA_IMM,  MODE_IMM, 8'h11, 8'h0A, 8'h80, 8'h0C, 8'h80, 8'h0A, 4'h8};
        tbl[13] = {OP_LDA_IDX,  MODE_IDX, 8'h22, 8'h0B, 8'h00, 8'h81, 8'h00, 8'h0B, 4'h4};
        tbl[14] = {OP_MUL,      MODE_IMM, 8'h0C, 8'h0D, 8'h00, 8'h50, 8'h00, 8'h9C, 4'h1};
        tbl[15] = {OP_MUL,      MODE_IMM, 8'hFF, 8'hFF, 8'h00, 8'hC0, 8'hFE, 8'h01, 4'h8};
        tbl[16] = {OP_MUL,      MODE_IMM, 8'h00, 8'h85, 8'h00, 8'h24, 8'h00, 8'h00, 4'hC};
        tbl[17] = {OP_BEQ,      MODE_IMM, 8'h05, 8'h01, 8'h05, 8'h00, 8'h00, 8'h01, 4'h4};
        tbl[18] = {OP_BEQ,      MODE_IMM, 8'h05, 8'h01, 8'h03, 8'hF8, 8'h02, 8'h01, 4'h0};
        tbl[19] = {OP_BNE,      MODE_IMM, 8'h05, 8'h02, 8'h03, 8'h00, 8'h02, 8'h02, 4'h0};
        tbl[20] = {OP_BNE,      MODE_IMM, 8'h09, 8'h02, 8'h09, 8'hF8, 8'h00, 8'h02, 4'h4};
        tbl[21] = {OP_BRA,      MODE_IMM, 8'h01, 8'h03, 8'h02, 8'h00, 8'hFF, 8'h03, 4'h9};
    endtask

    task automatic emit(input logic [7:0] v);
        mem[wp] = v;
        wp = wp + 16'd1;
    endtask

    task automatic load_program(input vec_t e, input logic [15:0] start);
        logic [15:0] base;
        int          i;
        base = 16'h4000 + {{8{e.off[7]}}, e.off};
        for (i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ {i[6:0], i[7]};
        end
        mem[16'hFFFE] = start[15:8];
        mem[16'hFFFF] = start[7:0];
        wp = start;
        emit(OP_LDA_IMM);
        emit(e.a);
        emit(OP_LDB_IMM);
        emit(e.b);
        emit(OP_LDX_IMM);
        emit(8'h40);
        emit(8'h00);
        if (is_branch(e.op)) begin
            // compare, then one of the two markers at X+30 or X+31
            emit(OP_SUBA_IMM);
            emit(e.opnd);
            emit(e.op);
            emit(8'h04);
            emit(OP_STB_IDX);
            emit(8'h30);
            emit(OP_BRA);
            emit(8'h02);
            emit(OP_STA_IDX);
            emit(8'h31);
        end else if (e.op == OP_MUL) begin
            emit(OP_MUL);
        end else begin
            emit(e.op);
            emit((e.mode == MODE_IDX) ? e.off : e.opnd);
            if (e.mode == MODE_IDX) begin
                mem[base] = e.opnd;
            end
        end
        emit(OP_STA_IDX);
        emit(e.off);
        emit(OP_STB_IDX);
        emit(e.off + 8'd1);
        emit(OP_STC_IDX);
        emit(e.off + 8'd2);
        // park on a branch to itself
        spin_addr = wp;
        emit(OP_BRA);
        emit(8'hFE);
    endtask

    task automatic check_entry(input int n, input vec_t e, input logic [15:0] start);
        logic [23:0] exp_q [$];
        logic [15:0] rd_exp [3];
        logic [15:0] base;
        logic        taken;
        int          k;
        base      = 16'h4000 + {{8{e.off[7]}}, e.off};
        rd_exp[0] = 16'hFFFE;
        rd_exp[1] = 16'hFFFF;
        rd_exp[2] = start;
        for (k = 0; k < 3; k++) begin
            checks++;
            if (rd_q[k] !== rd_exp[k]) begin
                errors++;
                $display("Mismatch entry %0d read %0d addr: expected %h, got %h",
                         n, k, rd_exp[k], rd_q[k]);
            end
        end
        if (is_branch(e.op)) begin
            taken = (e.op == OP_BRA) || (e.op == OP_BEQ && e.exp_cc[CC_Z]) ||
                    (e.op == OP_BNE && !e.exp_cc[CC_Z]);
            if (taken) begin
                exp_q.push_back({16'h4031, e.exp_a});
            end else begin
                exp_q.push_back({16'h4030, e.exp_b});
            end
        end
        exp_q.push_back({base, e.exp_a});
        exp_q.push_back({base + 16'd1, e.exp_b});
        exp_q.push_back({base + 16'd2, 4'h0, e.exp_cc});
        checks++;
        if (wr_q.size() != exp_q.size()) begin
            errors++;
            $display("entry %0d: expected %0d write cycles but saw %0d",
                     n, exp_q.size(), wr_q.size());
        end
        for (k = 0; k < exp_q.size() && k < wr_q.size(); k++) begin
            checks += 2;
            if (wr_q[k][23:8] !== exp_q[k][23:8]) begin
                errors++;
                $display("Mismatch entry %0d write %0d addr: expected %h, got %h",
                         n, k, exp_q[k][23:8], wr_q[k][23:8]);
            end
            if (wr_q[k][7:0] !== exp_q[k][7:0]) begin
                errors++;
                $display("Mismatch entry %0d write %0d dout: expected %h, got %h",
                         n, k, exp_q[k][7:0], wr_q[k][7:0]);
            end
        end
    endtask

    initial begin
        int          n;
        logic [15:0] start;
        rst  = 1'b1;
        halt = 1'b0;
        load_table();
        for (n = 0; n < NUM_VEC; n++) begin
            start = 16'h0100 + 16'(n) * 16'h0040;
            @(posedge clk);
            rst <= 1'b1;
            load_program(tbl[n], start);
            repeat (RST_CYCLES - 1) @(posedge clk);
            @(negedge clk);
            checks++;
            if (bus_req !== 1'b0 || we !== 1'b0) begin
                errors++;
                $display("entry %0d: bus_req or we active during reset", n);
            end
            @(posedge clk);
            rst <= 1'b0;
            while (!spin_hit) @(posedge clk);
            check_entry(n, tbl[n], start);
        end
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, DUT.u_chk.fail_cnt);
        if (errors == 0 && DUT.u_chk.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("watchdog: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
